// ==== filelist.f ====
hw/cpu_pkg.sv
hw/ex_mem_if.sv
hw/cpu_ifu.sv
hw/cpu_regfile.sv
hw/cpu_idu.sv
hw/cpu_exu.sv
hw/cpu_lsu.sv
hw/cpu_top.sv
tb/tb_cpu.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

SRCS := $(shell grep -v '^+' filelist.f)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) filelist.f
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(BUILD) -f filelist.f $(VFLAGS)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "ALL CHECKS PASSED" $(LOG)
	@! grep -q "CHECKS FAILED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== tb/tb_cpu.sv ====
module tb_cpu;
	import cpu_pkg::*;

	localparam int CLK_PERIOD = 4;
	localparam int TEST_COUNT = 6;
	localparam int CYCLES_PER_TEST = 2000;
	localparam int MEM_WORDS = 1024;

	logic  clk;
	logic  rst_n_i;
	logic  inst_ar_valid_o;
	addr_t inst_ar_addr_o;
	logic  inst_ar_ready_i;
	word_t inst_r_data_i;
	resp_t inst_r_resp_i;
	logic  inst_r_valid_i;
	logic  inst_r_ready_o;
	logic  data_ar_valid_o;
	addr_t data_ar_addr_o;
	logic  data_ar_ready_i;
	word_t data_r_data_i;
	resp_t data_r_resp_i;
	logic  data_r_valid_i;
	logic  data_r_ready_o;
	logic  data_aw_valid_o;
	addr_t data_aw_addr_o;
	logic  data_aw_ready_i;
	logic  data_w_valid_o;
	word_t data_w_data_o;
	logic  data_w_ready_i;
	resp_t data_b_resp_i;
	logic  data_b_valid_i;
	logic  data_b_ready_o;
	addr_t pc_o;
	logic  finish_o;
	logic  invalid_o;

	// shared memory for both ports
	word_t mem [0:MEM_WORDS-1];
	int    pc_w;
	addr_t dptr;
	addr_t exp_addr [$];
	word_t exp_data [$];
	addr_t got_addr [$];
	word_t got_data [$];

	logic [31:0] lfsr;
	bit    rand_mode;
	int    err_at;
	int    store_idx;
	int    fetch_count;
	int    errors;
	int    checks;
	int    tests;

	cpu_top cpu_top_inst (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
		$display("timeout: the run did not reach its end within the cycle budget");
		$display("CHECKS FAILED");
		$finish;
	end

	// galois lfsr, one step per bit
	function automatic logic next_bit();
		logic b;
		b = lfsr[0];
		lfsr = lfsr >> 1;
		if (b) lfsr = lfsr ^ 32'ha300_0000;
		return b;
	endfunction

	function automatic int rand_delay();
		logic [1:0] d;
		d = 2'b00;
		if (rand_mode) begin
			d[1] = next_bit();
			d[0] = next_bit();
		end
		return int'(d);
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic cycles(input int n);
		repeat (n) step();
	endtask

	// instruction port responder
	initial begin
		addr_t a;
		forever begin
			@(negedge clk);
			if (inst_ar_valid_o) begin
				a = inst_ar_addr_o;
				step();
				cycles(rand_delay());
				inst_ar_ready_i = 1'b1;
				step();
				inst_ar_ready_i = 1'b0;
				fetch_count++;
				cycles(rand_delay());
				inst_r_data_i  = mem[a[11:2]];
				inst_r_resp_i  = 2'b00;
				inst_r_valid_i = 1'b1;
				do @(negedge clk); while (!inst_r_ready_o);
				step();
				inst_r_valid_i = 1'b0;
			end
		end
	end

	// data read responder
	initial begin
		addr_t a;
		forever begin
			@(negedge clk);
			if (data_ar_valid_o) begin
				a = data_ar_addr_o;
				step();
				cycles(rand_delay());
				data_ar_ready_i = 1'b1;
				step();
				data_ar_ready_i = 1'b0;
				cycles(rand_delay());
				data_r_data_i  = mem[a[11:2]];
				data_r_resp_i  = 2'b00;
				data_r_valid_i = 1'b1;
				do @(negedge clk); while (!data_r_ready_o);
				step();
				data_r_valid_i = 1'b0;
			end
		end
	end

	// data write responder, aw and w run side by side
	initial begin
		addr_t a;
		word_t d;
		forever begin
			@(negedge clk);
			if (data_aw_valid_o || data_w_valid_o) begin
				a = data_aw_addr_o;
				d = data_w_data_o;
				step();
				fork
					begin
						cycles(rand_delay());
						data_aw_ready_i = 1'b1;
						step();
						data_aw_ready_i = 1'b0;
					end
					begin
						cycles(rand_delay());
						data_w_ready_i = 1'b1;
						step();
						data_w_ready_i = 1'b0;
					end
				join
				cycles(rand_delay());
				data_b_resp_i  = (store_idx == err_at) ? 2'b10 : 2'b00;
				data_b_valid_i = 1'b1;
				do @(negedge clk); while (!data_b_ready_o);
				step();
				data_b_valid_i = 1'b0;
				if (data_b_resp_i == 2'b00) begin
					mem[a[11:2]] = d;
					got_addr.push_back(a);
					got_data.push_back(d);
				end
				data_b_resp_i = 2'b00;
				store_idx++;
			end
		end
	end

	// RV32I encoders
	function automatic word_t enc_r(int f7, int rs2, int rs1, int f3, int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
	endfunction

	function automatic word_t enc_i(int imm, int rs1, int f3, int rd, logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic word_t enc_s(int imm, int rs2, int rs1);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t enc_b(int imm, int rs2, int rs1, int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			7'b1100011};
	endfunction

	function automatic word_t enc_u(int imm, int rd);
		return {imm[19:0], rd[4:0], 7'b0110111};
	endfunction

	function automatic word_t enc_j(int imm, int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'b1101111};
	endfunction

	task automatic emit(input word_t w);
		mem[pc_w] = w;
		pc_w++;
	endtask

	task automatic expect_store(input addr_t a, input word_t d);
		exp_addr.push_back(a);
		exp_data.push_back(d);
	endtask

	task automatic clear_program();
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
		end
		pc_w = 0;
		exp_addr.delete();
		exp_data.delete();
	endtask

	task automatic check_word(input word_t got, input word_t exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input bit got, input bit exp, input string what);
		checks++;
		if (got !== exp) begin
			$display("Fail %0t: %s is %0b, expected %0b", $time, what, got, exp);
			errors++;
		end
	endtask

	// every request and status output idle, pc at the start address
	task automatic check_reset_state();
		check_flag(inst_ar_valid_o, 1'b0, "inst_ar_valid_o in reset");
		check_flag(inst_r_ready_o, 1'b0, "inst_r_ready_o in reset");
		check_flag(data_ar_valid_o, 1'b0, "data_ar_valid_o in reset");
		check_flag(data_r_ready_o, 1'b0, "data_r_ready_o in reset");
		check_flag(data_aw_valid_o, 1'b0, "data_aw_valid_o in reset");
		check_flag(data_w_valid_o, 1'b0, "data_w_valid_o in reset");
		check_flag(data_b_ready_o, 1'b0, "data_b_ready_o in reset");
		check_flag(finish_o, 1'b0, "finish_o in reset");
		check_flag(invalid_o, 1'b0, "invalid_o in reset");
		check_addr(pc_o, 32'h0, "pc_o in reset");
	endtask

	// reset, run to halt, then compare flags and stores
	task automatic run_program(input bit exp_finish, input bit exp_invalid);
		rst_n_i = 1'b0;
		cycles(5);
		check_reset_state();
		got_addr.delete();
		got_data.delete();
		store_idx = 0;
		rst_n_i = 1'b1;
		do @(negedge clk); while (!(finish_o || invalid_o));
		cycles(2);
		check_flag(finish_o, exp_finish, "finish_o");
		check_flag(invalid_o, exp_invalid, "invalid_o");
		checks++;
		if (got_addr.size() != exp_addr.size()) begin
			$display("store count is %0d but %0d stores were expected",
				got_addr.size(), exp_addr.size());
			errors++;
		end
		for (int i = 0; i < got_addr.size() && i < exp_addr.size(); i++) begin
			check_addr(got_addr[i], exp_addr[i], $sformatf("store %0d address", i));
			check_word(got_data[i], exp_data[i], $sformatf("store %0d data", i));
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests++;
		if (errors == err_before) $display("test %s: ok", name);
		else $display("test %s: %0d errors", name, errors - err_before);
	endtask

	task automatic alu_case(input word_t inst, input word_t expv);
		emit(inst);
		emit(enc_s(dptr, 4, 0));
		expect_store(dptr, expv);
		dptr += 4;
	endtask

	task automatic build_alu();
		word_t a;
		word_t b;
		a = 32'd1234;
		b = -32'sd7;
		clear_program();
		dptr = 32'h200;
		emit(enc_i(1234, 0, 0, 1, 7'b0010011));
		emit(enc_i(-7, 0, 0, 2, 7'b0010011));
		emit(enc_u('habcde, 3));
		emit(enc_i(5, 0, 0, 5, 7'b0010011));
		alu_case(enc_r(0, 2, 1, 0, 4), a + b);
		alu_case(enc_r(32, 2, 1, 0, 4), a - b);
		alu_case(enc_r(0, 2, 1, 7, 4), a & b);
		alu_case(enc_r(0, 2, 1, 6, 4), a | b);
		alu_case(enc_r(0, 2, 1, 4, 4), a ^ b);
		alu_case(enc_r(0, 2, 1, 2, 4), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
		alu_case(enc_r(0, 1, 2, 2, 4), ($signed(b) < $signed(a)) ? 32'd1 : 32'd0);
		alu_case(enc_r(0, 5, 1, 1, 4), a << 5);
		alu_case(enc_r(0, 5, 2, 5, 4), b >> 5);
		alu_case(enc_i(-100, 1, 0, 4, 7'b0010011), a - 32'd100);
		alu_case(enc_i('h0f0, 2, 7, 4, 7'b0010011), b & 32'h0f0);
		alu_case(enc_i('h300, 1, 6, 4, 7'b0010011), a | 32'h300);
		alu_case(enc_i('h555, 2, 4, 4, 7'b0010011), b ^ 32'h555);
		alu_case(enc_i(-3, 2, 2, 4, 7'b0010011), ($signed(b) < -3) ? 32'd1 : 32'd0);
		alu_case(enc_i(3, 1, 1, 4, 7'b0010011), a << 3);
		alu_case(enc_i(4, 2, 5, 4, 7'b0010011), b >> 4);
		alu_case(enc_i(0, 3, 0, 4, 7'b0010011), 32'habcd_e000);
		emit(32'h0010_0073);
	endtask

	task automatic build_mem();
		clear_program();
		emit(enc_i('h111, 0, 0, 1, 7'b0010011));
		emit(enc_u('h12345, 2));
		emit(enc_i('h678, 2, 0, 2, 7'b0010011));
		emit(enc_s('h300, 1, 0));
		expect_store(32'h300, 32'h111);
		emit(enc_s('h304, 2, 0));
		expect_store(32'h304, 32'h1234_5678);
		emit(enc_i('h304, 0, 2, 6, 7'b0000011));
		emit(enc_i('h300, 0, 2, 7, 7'b0000011));
		emit(enc_s('h310, 6, 0));
		expect_store(32'h310, 32'h1234_5678);
		emit(enc_s('h314, 7, 0));
		expect_store(32'h314, 32'h111);
		// x0 stays zero after both kinds of write
		emit(enc_i(55, 0, 0, 0, 7'b0010011));
		emit(enc_s('h318, 0, 0));
		expect_store(32'h318, 32'h0);
		emit(enc_i('h304, 0, 2, 0, 7'b0000011));
		emit(enc_s('h31c, 0, 0));
		expect_store(32'h31c, 32'h0);
		emit(32'h0010_0073);
	endtask

	task automatic build_ctrl();
		addr_t j;
		clear_program();
		emit(enc_i(5, 0, 0, 1, 7'b0010011));
		emit(enc_i(5, 0, 0, 2, 7'b0010011));
		emit(enc_i(9, 0, 0, 3, 7'b0010011));
		// taken branches jump over their marker
		emit(enc_b(8, 2, 1, 0));
		emit(enc_s('h400, 1, 0));
		emit(enc_b(8, 3, 1, 0));
		emit(enc_s('h404, 1, 0));
		expect_store(32'h404, 32'd5);
		emit(enc_b(8, 3, 1, 1));
		emit(enc_s('h408, 1, 0));
		emit(enc_b(8, 2, 1, 1));
		emit(enc_s('h40c, 3, 0));
		expect_store(32'h40c, 32'd9);
		j = pc_w * 4;
		emit(enc_j(8, 5));
		emit(enc_s('h410, 1, 0));
		emit(enc_s('h414, 5, 0));
		expect_store(32'h414, j + 32'd4);
		emit(32'h0010_0073);
	endtask

	task automatic test_alu();
		int e;
		e = errors;
		build_alu();
		run_program(1'b1, 1'b0);
		report_test("alu", e);
	endtask

	task automatic test_load_store();
		int e;
		e = errors;
		build_mem();
		run_program(1'b1, 1'b0);
		report_test("load_store", e);
	endtask

	task automatic test_control();
		int e;
		e = errors;
		build_ctrl();
		run_program(1'b1, 1'b0);
		report_test("control", e);
	endtask

	task automatic test_backpressure();
		int e;
		e = errors;
		rand_mode = 1'b1;
		build_alu();
		run_program(1'b1, 1'b0);
		build_mem();
		run_program(1'b1, 1'b0);
		build_ctrl();
		run_program(1'b1, 1'b0);
		rand_mode = 1'b0;
		report_test("backpressure", e);
	endtask

	task automatic test_illegal();
		int e;
		e = errors;
		clear_program();
		emit(enc_i(3, 0, 0, 1, 7'b0010011));
		emit(enc_s('h500, 1, 0));
		expect_store(32'h500, 32'd3);
		emit(32'h0000_007f);
		emit(enc_s('h504, 1, 0));
		emit(32'h0010_0073);
		run_program(1'b0, 1'b1);
		check_addr(pc_o, 32'h8, "pc_o at halt");
		cycles(10);
		check_addr(pc_o, 32'h8, "pc_o after halt");
		report_test("illegal", e);
	endtask

	task automatic test_error_resp();
		int e;
		e = errors;
		clear_program();
		emit(enc_i(7, 0, 0, 1, 7'b0010011));
		emit(enc_s('h600, 1, 0));
		expect_store(32'h600, 32'd7);
		emit(enc_s('h604, 1, 0));
		emit(enc_s('h608, 1, 0));
		emit(32'h0010_0073);
		err_at = 1;
		fetch_count = 0;
		run_program(1'b0, 1'b1);
		cycles(20);
		checks++;
		// the failing store is the third fetch and the last one
		if (fetch_count != 3 || inst_ar_valid_o) begin
			$display("a fetch was issued after the error response, %0d fetches in all",
				fetch_count);
			errors++;
		end
		err_at = -1;
		report_test("error_resp", e);
	endtask

	initial begin
		rst_n_i = 1'b0;
		inst_ar_ready_i = 1'b0;
		inst_r_data_i = '0;
		inst_r_resp_i = '0;
		inst_r_valid_i = 1'b0;
		data_ar_ready_i = 1'b0;
		data_r_data_i = '0;
		data_r_resp_i = '0;
		data_r_valid_i = 1'b0;
		data_aw_ready_i = 1'b0;
		data_w_ready_i = 1'b0;
		data_b_resp_i = '0;
		data_b_valid_i = 1'b0;
		lfsr = 32'hd9af348e;
		rand_mode = 1'b0;
		err_at = -1;
		store_idx = 0;
		fetch_count = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		step();
		test_alu();
		test_load_store();
		test_control();
		test_backpressure();
		test_illegal();
		test_error_resp();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// ==== hw/cpu_top.sv ====
module cpu_top (
	input  logic           clk,
	input  logic           rst_n_i,
	output logic           inst_ar_valid_o,
	output cpu_pkg::addr_t inst_ar_addr_o,
	input  logic           inst_ar_ready_i,
	input  cpu_pkg::word_t inst_r_data_i,
	input  cpu_pkg::resp_t inst_r_resp_i,
	input  logic           inst_r_valid_i,
	output logic           inst_r_ready_o,
	output logic           data_ar_valid_o,
	output cpu_pkg::addr_t data_ar_addr_o,
	input  logic           data_ar_ready_i,
	input  cpu_pkg::word_t data_r_data_i,
	input  cpu_pkg::resp_t data_r_resp_i,
	input  logic           data_r_valid_i,
	output logic           data_r_ready_o,
	output logic           data_aw_valid_o,
	output cpu_pkg::addr_t data_aw_addr_o,
	input  logic           data_aw_ready_i,
	output logic           data_w_valid_o,
	output cpu_pkg::word_t data_w_data_o,
	input  logic           data_w_ready_i,
	input  cpu_pkg::resp_t data_b_resp_i,
	input  logic           data_b_valid_i,
	output logic           data_b_ready_o,
	output cpu_pkg::addr_t pc_o,
	output logic           finish_o,
	output logic           invalid_o
);
	import cpu_pkg::*;

	word_t    inst;
	logic     issue;
	logic     done;
	logic     lsu_err;
	logic     redirect;
	addr_t    target;
	reg_idx_t raddr1;
	reg_idx_t raddr2;
	word_t    rdata1;
	word_t    rdata2;
	logic     reg_wen;
	reg_idx_t reg_waddr;
	word_t    reg_wdata;
	alu_op_e  alu_op;
	word_t    opa;
	word_t    opb;
	word_t    imm;
	reg_idx_t rd;
	logic     wen;
	logic     is_load;
	logic     is_store;
	logic     is_branch;
	logic     branch_ne;
	logic     is_jal;
	logic     ebreak;
	logic     illegal;

	ex_mem_if ex_mem ();

	cpu_ifu cpu_ifu_inst (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.inst_ar_ready_i (inst_ar_ready_i),
		.inst_r_data_i   (inst_r_data_i),
		.inst_r_resp_i   (inst_r_resp_i),
		.inst_r_valid_i  (inst_r_valid_i),
		.done_i          (done),
		.redirect_i      (redirect),
		.target_i        (target),
		.ebreak_i        (ebreak),
		.illegal_i       (illegal),
		.lsu_err_i       (lsu_err),
		.inst_ar_valid_o (inst_ar_valid_o),
		.inst_ar_addr_o  (inst_ar_addr_o),
		.inst_r_ready_o  (inst_r_ready_o),
		.inst_o          (inst),
		.pc_o            (pc_o),
		.issue_o         (issue),
		.finish_o        (finish_o),
		.invalid_o       (invalid_o)
	);

	cpu_regfile cpu_regfile_inst (
		.clk      (clk),
		.rst_n_i  (rst_n_i),
		.raddr1_i (raddr1),
		.raddr2_i (raddr2),
		.waddr_i  (reg_waddr),
		.wen_i    (reg_wen),
		.wdata_i  (reg_wdata),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2)
	);

	cpu_idu cpu_idu_inst (
		.inst_i      (inst),
		.rdata1_i    (rdata1),
		.rdata2_i    (rdata2),
		.raddr1_o    (raddr1),
		.raddr2_o    (raddr2),
		.alu_op_o    (alu_op),
		.opa_o       (opa),
		.opb_o       (opb),
		.imm_o       (imm),
		.rd_o        (rd),
		.wen_o       (wen),
		.is_load_o   (is_load),
		.is_store_o  (is_store),
		.is_branch_o (is_branch),
		.branch_ne_o (branch_ne),
		.is_jal_o    (is_jal),
		.ebreak_o    (ebreak),
		.illegal_o   (illegal)
	);

	cpu_exu cpu_exu_inst (
		.issue_i      (issue),
		.pc_i         (pc_o),
		.alu_op_i     (alu_op),
		.opa_i        (opa),
		.opb_i        (opb),
		.imm_i        (imm),
		.rd_i         (rd),
		.wen_i        (wen),
		.is_load_i    (is_load),
		.is_store_i   (is_store),
		.is_branch_i  (is_branch),
		.branch_ne_i  (branch_ne),
		.is_jal_i     (is_jal),
		.store_data_i (rdata2),
		.redirect_o   (redirect),
		.target_o     (target),
		.ex_o         (ex_mem)
	);

	cpu_lsu cpu_lsu_inst (
		.clk             (clk),
		.rst_n_i         (rst_n_i),
		.ex_i            (ex_mem),
		.data_ar_valid_o (data_ar_valid_o),
		.data_ar_addr_o  (data_ar_addr_o),
		.data_ar_ready_i (data_ar_ready_i),
		.data_r_data_i   (data_r_data_i),
		.data_r_resp_i   (data_r_resp_i),
		.data_r_valid_i  (data_r_valid_i),
		.data_r_ready_o  (data_r_ready_o),
		.data_aw_valid_o (data_aw_valid_o),
		.data_aw_addr_o  (data_aw_addr_o),
		.data_aw_ready_i (data_aw_ready_i),
		.data_w_valid_o  (data_w_valid_o),
		.data_w_data_o   (data_w_data_o),
		.data_w_ready_i  (data_w_ready_i),
		.data_b_resp_i   (data_b_resp_i),
		.data_b_valid_i  (data_b_valid_i),
		.data_b_ready_o  (data_b_ready_o),
		.reg_wen_o       (reg_wen),
		.reg_waddr_o     (reg_waddr),
		.reg_wdata_o     (reg_wdata),
		.done_o          (done),
		.err_o           (lsu_err)
	);

endmodule

// ==== hw/cpu_lsu.sv ====
module cpu_lsu (
	input  logic              clk,
	input  logic              rst_n_i,
	ex_mem_if.lsu             ex_i,
	output logic              data_ar_valid_o,
	output cpu_pkg::addr_t    data_ar_addr_o,
	input  logic              data_ar_ready_i,
	input  cpu_pkg::word_t    data_r_data_i,
	input  cpu_pkg::resp_t    data_r_resp_i,
	input  logic              data_r_valid_i,
	output logic              data_r_ready_o,
	output logic              data_aw_valid_o,
	output cpu_pkg::addr_t    data_aw_addr_o,
	input  logic              data_aw_ready_i,
	output logic              data_w_valid_o,
	output cpu_pkg::word_t    data_w_data_o,
	input  logic              data_w_ready_i,
	input  cpu_pkg::resp_t    data_b_resp_i,
	input  logic              data_b_valid_i,
	output logic              data_b_ready_o,
	output logic              reg_wen_o,
	output cpu_pkg::reg_idx_t reg_waddr_o,
	output cpu_pkg::word_t    reg_wdata_o,
	output logic              done_o,
	output logic              err_o
);
	import cpu_pkg::*;

	lsu_state_e state_q;
	reg_idx_t   rd_q;
	addr_t      addr_q;
	word_t      wdata_q;
	logic       aw_pend_q;
	logic       w_pend_q;
	logic       aw_fin;
	logic       w_fin;

	// each write channel finishes on its own handshake
	assign aw_fin = !aw_pend_q || data_aw_ready_i;
	assign w_fin  = !w_pend_q || data_w_ready_i;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q   <= LSU_IDLE;
			aw_pend_q <= 1'b0;
			w_pend_q  <= 1'b0;
		end else begin
			case (state_q)
				LSU_IDLE: begin
					if (ex_i.valid && ex_i.is_load) begin
						state_q <= LSU_RADDR;
					end else if (ex_i.valid && ex_i.is_store) begin
						aw_pend_q <= 1'b1;
						w_pend_q  <= 1'b1;
						state_q   <= LSU_WRITE;
					end
				end
				LSU_RADDR: if (data_ar_ready_i) state_q <= LSU_RDATA;
				LSU_RDATA: if (data_r_valid_i) state_q <= LSU_IDLE;
				LSU_WRITE: begin
					if (data_aw_ready_i) aw_pend_q <= 1'b0;
					if (data_w_ready_i) w_pend_q <= 1'b0;
					if (aw_fin && w_fin) state_q <= LSU_WRESP;
				end
				LSU_WRESP: if (data_b_valid_i) state_q <= LSU_IDLE;
				default: state_q <= LSU_IDLE;
			endcase
		end
	end

	// instruction fields held for the whole access
	always_ff @(posedge clk) begin
		if (state_q == LSU_IDLE && ex_i.valid) begin
			rd_q    <= ex_i.rd;
			addr_q  <= ex_i.result;
			wdata_q <= ex_i.store_data;
		end
	end

	assign data_ar_valid_o = (state_q == LSU_RADDR);
	assign data_ar_addr_o  = addr_q;
	assign data_r_ready_o  = (state_q == LSU_RDATA);
	assign data_aw_valid_o = aw_pend_q;
	assign data_aw_addr_o  = addr_q;
	assign data_w_valid_o  = w_pend_q;
	assign data_w_data_o   = wdata_q;
	assign data_b_ready_o  = (state_q == LSU_WRESP);

	// write-back select and completion
	always_comb begin
		reg_wen_o   = 1'b0;
		reg_waddr_o = ex_i.rd;
		reg_wdata_o = ex_i.result;
		done_o      = 1'b0;
		err_o       = 1'b0;
		case (state_q)
			LSU_IDLE: begin
				if (ex_i.valid && !ex_i.is_load && !ex_i.is_store) begin
					reg_wen_o = ex_i.wen;
					done_o    = 1'b1;
				end
			end
			LSU_RDATA: begin
				reg_waddr_o = rd_q;
				reg_wdata_o = data_r_data_i;
				if (data_r_valid_i) begin
					err_o     = (data_r_resp_i != '0);
					reg_wen_o = (data_r_resp_i == '0);
					done_o    = (data_r_resp_i == '0);
				end
			end
			LSU_WRESP: begin
				if (data_b_valid_i) begin
					err_o  = (data_b_resp_i != '0);
					done_o = (data_b_resp_i == '0);
				end
			end
			default: begin
				done_o = 1'b0;
			end
		endcase
	end

endmodule

// ==== hw/cpu_exu.sv ====
module cpu_exu (
	input  logic              issue_i,
	input  cpu_pkg::addr_t    pc_i,
	input  cpu_pkg::alu_op_e  alu_op_i,
	input  cpu_pkg::word_t    opa_i,
	input  cpu_pkg::word_t    opb_i,
	input  cpu_pkg::word_t    imm_i,
	input  cpu_pkg::reg_idx_t rd_i,
	input  logic              wen_i,
	input  logic              is_load_i,
	input  logic              is_store_i,
	input  logic              is_branch_i,
	input  logic              branch_ne_i,
	input  logic              is_jal_i,
	input  cpu_pkg::word_t    store_data_i,
	output logic              redirect_o,
	output cpu_pkg::addr_t    target_o,
	ex_mem_if.exu             ex_o
);
	import cpu_pkg::*;

	word_t alu_res;
	logic  taken;

	always_comb begin
		case (alu_op_i)
			ALU_ADD:    alu_res = opa_i + opb_i;
			ALU_SUB:    alu_res = opa_i - opb_i;
			ALU_AND:    alu_res = opa_i & opb_i;
			ALU_OR:     alu_res = opa_i | opb_i;
			ALU_XOR:    alu_res = opa_i ^ opb_i;
			ALU_SLT:    alu_res = {{(XLEN-1){1'b0}}, $signed(opa_i) < $signed(opb_i)};
			ALU_SLL:    alu_res = opa_i << opb_i[4:0];
			ALU_SRL:    alu_res = opa_i >> opb_i[4:0];
			default:    alu_res = opb_i;
		endcase
	end

	// beq or bne on the register operands
	assign taken      = branch_ne_i ? (opa_i != opb_i) : (opa_i == opb_i);
	assign redirect_o = is_jal_i || (is_branch_i && taken);
	assign target_o   = pc_i + imm_i;

	assign ex_o.valid      = issue_i;
	assign ex_o.is_load    = is_load_i;
	assign ex_o.is_store   = is_store_i;
	assign ex_o.wen        = wen_i;
	assign ex_o.rd         = rd_i;
	// jal links pc + 4
	assign ex_o.result     = is_jal_i ? pc_i + 32'd4 : alu_res;
	assign ex_o.store_data = store_data_i;

endmodule

// ==== hw/cpu_idu.sv ====
module cpu_idu (
	input  cpu_pkg::word_t    inst_i,
	input  cpu_pkg::word_t    rdata1_i,
	input  cpu_pkg::word_t    rdata2_i,
	output cpu_pkg::reg_idx_t raddr1_o,
	output cpu_pkg::reg_idx_t raddr2_o,
	output cpu_pkg::alu_op_e  alu_op_o,
	output cpu_pkg::word_t    opa_o,
	output cpu_pkg::word_t    opb_o,
	output cpu_pkg::word_t    imm_o,
	output cpu_pkg::reg_idx_t rd_o,
	output logic              wen_o,
	output logic              is_load_o,
	output logic              is_store_o,
	output logic              is_branch_o,
	output logic              branch_ne_o,
	output logic              is_jal_o,
	output logic              ebreak_o,
	output logic              illegal_o
);
	import cpu_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       is_reg;
	logic       f7_ok;
	word_t      imm_i_w;
	word_t      imm_s_w;
	word_t      imm_b_w;
	word_t      imm_u_w;
	word_t      imm_j_w;

	assign opcode = inst_i[6:0];
	assign funct3 = inst_i[14:12];
	assign funct7 = inst_i[31:25];
	assign is_reg = (opcode == OPC_OP);

	assign imm_i_w = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_s_w = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
	assign imm_b_w = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u_w = {inst_i[31:12], 12'b0};
	assign imm_j_w = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	// only SUB may set funct7 in register form; immediate shifts need zero
	always_comb begin
		if (is_reg) begin
			f7_ok = (funct7 == 7'b0) || (funct7 == 7'b0100000 && funct3 == 3'b000);
		end else begin
			f7_ok = (funct3 != 3'b001 && funct3 != 3'b101) || (funct7 == 7'b0);
		end
	end

	assign raddr1_o = inst_i[19:15];
	assign raddr2_o = inst_i[24:20];
	assign rd_o     = inst_i[11:7];
	assign opa_o    = rdata1_i;

	always_comb begin
		alu_op_o    = ALU_ADD;
		opb_o       = rdata2_i;
		imm_o       = imm_i_w;
		wen_o       = 1'b0;
		is_load_o   = 1'b0;
		is_store_o  = 1'b0;
		is_branch_o = 1'b0;
		branch_ne_o = 1'b0;
		is_jal_o    = 1'b0;
		ebreak_o    = 1'b0;
		illegal_o   = 1'b0;
		case (opcode)
			OPC_OP, OPC_OP_IMM: begin
				wen_o     = 1'b1;
				opb_o     = is_reg ? rdata2_i : imm_i_w;
				illegal_o = !f7_ok;
				case (funct3)
					3'b000: alu_op_o = (is_reg && funct7[5]) ? ALU_SUB : ALU_ADD;
					3'b001: alu_op_o = ALU_SLL;
					3'b010: alu_op_o = ALU_SLT;
					3'b100: alu_op_o = ALU_XOR;
					3'b101: alu_op_o = ALU_SRL;
					3'b110: alu_op_o = ALU_OR;
					3'b111: alu_op_o = ALU_AND;
					default: illegal_o = 1'b1;
				endcase
			end
			OPC_LUI: begin
				wen_o    = 1'b1;
				alu_op_o = ALU_PASS_B;
				imm_o    = imm_u_w;
				opb_o    = imm_u_w;
			end
			OPC_LOAD: begin
				wen_o     = 1'b1;
				is_load_o = 1'b1;
				opb_o     = imm_i_w;
				illegal_o = (funct3 != 3'b010);
			end
			OPC_STORE: begin
				is_store_o = 1'b1;
				imm_o      = imm_s_w;
				opb_o      = imm_s_w;
				illegal_o  = (funct3 != 3'b010);
			end
			OPC_BRANCH: begin
				is_branch_o = 1'b1;
				branch_ne_o = funct3[0];
				imm_o       = imm_b_w;
				illegal_o   = (funct3[2:1] != 2'b00);
			end
			OPC_JAL: begin
				wen_o    = 1'b1;
				is_jal_o = 1'b1;
				imm_o    = imm_j_w;
			end
			OPC_SYSTEM: begin
				ebreak_o  = (inst_i == INST_EBREAK);
				illegal_o = (inst_i != INST_EBREAK);
			end
			default: illegal_o = 1'b1;
		endcase
		// an illegal word must leave no side effects
		if (illegal_o) begin
			wen_o      = 1'b0;
			is_load_o  = 1'b0;
			is_store_o = 1'b0;
		end
	end

endmodule

// ==== hw/cpu_regfile.sv ====
module cpu_regfile (
	input  logic              clk,
	input  logic              rst_n_i,
	input  cpu_pkg::reg_idx_t raddr1_i,
	input  cpu_pkg::reg_idx_t raddr2_i,
	input  cpu_pkg::reg_idx_t waddr_i,
	input  logic              wen_i,
	input  cpu_pkg::word_t    wdata_i,
	output cpu_pkg::word_t    rdata1_o,
	output cpu_pkg::word_t    rdata2_o
);
	import cpu_pkg::*;

	// x0 has no storage
	word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

// ==== hw/cpu_ifu.sv ====
module cpu_ifu (
	input  logic           clk,
	input  logic           rst_n_i,
	input  logic           inst_ar_ready_i,
	input  cpu_pkg::word_t inst_r_data_i,
	input  cpu_pkg::resp_t inst_r_resp_i,
	input  logic           inst_r_valid_i,
	input  logic           done_i,
	input  logic           redirect_i,
	input  cpu_pkg::addr_t target_i,
	input  logic           ebreak_i,
	input  logic           illegal_i,
	input  logic           lsu_err_i,
	output logic           inst_ar_valid_o,
	output cpu_pkg::addr_t inst_ar_addr_o,
	output logic           inst_r_ready_o,
	output cpu_pkg::word_t inst_o,
	output cpu_pkg::addr_t pc_o,
	output logic           issue_o,
	output logic           finish_o,
	output logic           invalid_o
);
	import cpu_pkg::*;

	ifu_state_e state_q;
	addr_t      pc_q;
	word_t      inst_q;
	logic       ar_valid_q;
	logic       issue_q;
	logic       finish_q;
	logic       invalid_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			state_q    <= IFU_ADDR;
			pc_q       <= RESET_PC;
			ar_valid_q <= 1'b0;
			issue_q    <= 1'b0;
			finish_q   <= 1'b0;
			invalid_q  <= 1'b0;
		end else begin
			issue_q <= 1'b0;
			case (state_q)
				IFU_ADDR: begin
					if (!ar_valid_q) begin
						// first request after reset
						ar_valid_q <= 1'b1;
					end else if (inst_ar_ready_i) begin
						ar_valid_q <= 1'b0;
						state_q    <= IFU_DATA;
					end
				end
				IFU_DATA: begin
					if (inst_r_valid_i) begin
						if (inst_r_resp_i != '0) begin
							invalid_q <= 1'b1;
							state_q   <= IFU_HALT;
						end else begin
							issue_q <= 1'b1;
							state_q <= IFU_BUSY;
						end
					end
				end
				IFU_BUSY: begin
					// halt checks win over a done in the issue cycle
					if (issue_q && ebreak_i) begin
						finish_q <= 1'b1;
						state_q  <= IFU_HALT;
					end else if ((issue_q && illegal_i) || lsu_err_i) begin
						invalid_q <= 1'b1;
						state_q   <= IFU_HALT;
					end else if (done_i) begin
						pc_q       <= redirect_i ? target_i : pc_q + 32'd4;
						ar_valid_q <= 1'b1;
						state_q    <= IFU_ADDR;
					end
				end
				default: begin
					// halted until reset
					state_q <= IFU_HALT;
				end
			endcase
		end
	end

	// instruction word, no reset needed
	always_ff @(posedge clk) begin
		if (state_q == IFU_DATA && inst_r_valid_i) begin
			inst_q <= inst_r_data_i;
		end
	end

	assign inst_ar_valid_o = ar_valid_q;
	assign inst_ar_addr_o  = pc_q;
	assign inst_r_ready_o  = (state_q == IFU_DATA);
	assign inst_o          = inst_q;
	assign pc_o            = pc_q;
	assign issue_o         = issue_q;
	assign finish_o        = finish_q;
	assign invalid_o       = invalid_q;

endmodule

// ==== hw/ex_mem_if.sv ====
interface ex_mem_if;
	import cpu_pkg::*;

	logic     valid;
	logic     is_load;
	logic     is_store;
	logic     wen;
	reg_idx_t rd;
	// alu result, doubles as the memory address
	word_t    result;
	word_t    store_data;

	modport exu (
		output valid, is_load, is_store, wen, rd, result, store_data
	);

	modport lsu (
		input valid, is_load, is_store, wen, rd, result, store_data
	);

endinterface

// ==== hw/cpu_pkg.sv ====
package cpu_pkg;

	localparam int XLEN = 32;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [XLEN-1:0] addr_t;
	typedef logic [4:0]      reg_idx_t;
	// channel response, zero is okay
	typedef logic [1:0]      resp_t;

	localparam addr_t RESET_PC = '0;

	// major opcodes
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// the one SYSTEM encoding we accept
	localparam word_t INST_EBREAK = 32'h0010_0073;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLL,
		ALU_SRL,
		ALU_PASS_B
	} alu_op_e;

	typedef enum logic [1:0] {
		IFU_ADDR,
		IFU_DATA,
		IFU_BUSY,
		IFU_HALT
	} ifu_state_e;

	typedef enum logic [2:0] {
		LSU_IDLE,
		LSU_RADDR,
		LSU_RDATA,
		LSU_WRITE,
		LSU_WRESP
	} lsu_state_e;

endpackage
